/* build.f */
+incdir+logic
logic/pext_pkg.sv
logic/pext_op_decoder.sv
logic/pext_unary_decoder.sv
logic/pext_decode_merge.sv
logic/pext_decoder_top.sv
test/pext_decoder_properties.sv
test/pext_decoder_tb.sv

/* logic/pext_decode_merge.sv */
//////////////////////////////
// Picks the decoder that matched, derives width and sign
// Result is registered, valid one cycle after the strobe
//////////////////////////////

`timescale 1ns/1ps

module pext_decode_merge import pext_pkg::*; (
  input  logic         clk_i,
  input  logic         arst_n_i,
  input  logic         instr_valid_i,
  input  op_hit_t      table_hit_i,
  input  op_hit_t      unary_hit_i,
  input  subf5_t       imm_i,
  output logic         decode_valid_o,
  output pext_decode_t decode_o
);

  pext_op_e     sel_op;
  pext_decode_t decode_d;

  // At most one part can hit, no funct7 code is shared
  always_comb begin
    if (table_hit_i.hit) begin
      sel_op = table_hit_i.op;
    end else if (unary_hit_i.hit) begin
      sel_op = unary_hit_i.op;
    end else begin
      sel_op = PEXT_OP_NONE;
    end
  end

  //////////////////////////////
  // Attribute classification
  //////////////////////////////
  always_comb begin
    decode_d           = '0;
    decode_d.op        = sel_op;
    decode_d.illegal   = ~(table_hit_i.hit | unary_hit_i.hit);
    decode_d.imm       = imm_i;
    decode_d.imm_instr = sel_op inside {PEXT_OP_SRAI16, PEXT_OP_SRLI16, PEXT_OP_SLLI16,
                                        PEXT_OP_SRAI8,  PEXT_OP_SRLI8,  PEXT_OP_SLLI8};
    case (sel_op)
      PEXT_OP_KADDW, PEXT_OP_RADDW, PEXT_OP_KSUBW, PEXT_OP_RSUBW,
      PEXT_OP_KABSW, PEXT_OP_CLRS32: begin
        decode_d.width32   = 1'b1;
        decode_d.signed_op = 1'b1;
      end
      PEXT_OP_UKADDW, PEXT_OP_URADDW, PEXT_OP_UKSUBW, PEXT_OP_URSUBW: begin
        decode_d.width32   = 1'b1;
      end
      PEXT_OP_ADD16, PEXT_OP_KADD16, PEXT_OP_RADD16, PEXT_OP_SUB16, PEXT_OP_KSUB16,
      PEXT_OP_RSUB16, PEXT_OP_CMPEQ16, PEXT_OP_SCMPLT16, PEXT_OP_SCMPLE16,
      PEXT_OP_SMIN16, PEXT_OP_SMAX16, PEXT_OP_SRA16, PEXT_OP_SRAI16,
      PEXT_OP_KABS16, PEXT_OP_CLRS16: begin
        decode_d.signed_op = 1'b1;
      end
      PEXT_OP_ADD8, PEXT_OP_KADD8, PEXT_OP_RADD8, PEXT_OP_SUB8, PEXT_OP_KSUB8,
      PEXT_OP_RSUB8, PEXT_OP_CMPEQ8, PEXT_OP_SCMPLT8, PEXT_OP_SCMPLE8,
      PEXT_OP_SMIN8, PEXT_OP_SMAX8, PEXT_OP_SRA8, PEXT_OP_SRAI8,
      PEXT_OP_KABS8, PEXT_OP_CLRS8: begin
        decode_d.width8    = 1'b1;
        decode_d.signed_op = 1'b1;
      end
      PEXT_OP_UKADD8, PEXT_OP_URADD8, PEXT_OP_UKSUB8, PEXT_OP_URSUB8,
      PEXT_OP_UCMPLT8, PEXT_OP_UCMPLE8, PEXT_OP_UMIN8, PEXT_OP_UMAX8,
      PEXT_OP_SRL8, PEXT_OP_SRLI8, PEXT_OP_SLL8, PEXT_OP_SLLI8, PEXT_OP_CLZ8: begin
        decode_d.width8    = 1'b1;
      end
      // Unsigned 16-bit and NONE keep every attribute clear
      default: ;
    endcase
  end

  //////////////////////////////
  // Output register
  //////////////////////////////
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      decode_valid_o <= 1'b0;
      decode_o       <= '0;
    end else begin
      decode_valid_o <= instr_valid_i;
      if (instr_valid_i) begin
        decode_o <= decode_d;
      end
    end
  end

endmodule

/* logic/pext_decoder_top.sv */
//////////////////////////////
// Packed-SIMD decoder top, strobe in and result one cycle later
// No back-pressure, take each result in its valid cycle
//////////////////////////////

`timescale 1ns/1ps

`include "pext_params.svh"

module pext_decoder_top import pext_pkg::*; (
  input  logic         clk_i,
  input  logic         arst_n_i,
  input  logic         instr_valid_i,
  input  instr_t       instr_i,
  output logic         decode_valid_o,
  output pext_decode_t decode_o
);

  funct3_t funct3;
  funct7_t funct7;
  subf5_t  subf5;
  op_hit_t table_hit;
  op_hit_t unary_hit;

  // Field split, subf5 doubles as the shift immediate
  assign funct3 = instr_i[`PEXT_FUNCT3_LSB +: `PEXT_FUNCT3_W];
  assign funct7 = instr_i[`PEXT_FUNCT7_LSB +: `PEXT_FUNCT7_W];
  assign subf5  = instr_i[`PEXT_SUBF5_LSB +: `PEXT_SUBF5_W];

  pext_op_decoder i_pext_op_decoder (
    .funct3_i    (funct3),
    .funct7_i    (funct7),
    .table_hit_o (table_hit)
  );

  pext_unary_decoder i_pext_unary_decoder (
    .funct3_i    (funct3),
    .funct7_i    (funct7),
    .subf5_i     (subf5),
    .unary_hit_o (unary_hit)
  );

  pext_decode_merge i_pext_decode_merge (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .instr_valid_i  (instr_valid_i),
    .table_hit_i    (table_hit),
    .unary_hit_i    (unary_hit),
    .imm_i          (subf5),
    .decode_valid_o (decode_valid_o),
    .decode_o       (decode_o)
  );

endmodule

/* logic/pext_op_decoder.sv */
//////////////////////////////
// Two-operand operator table, funct3 first then funct7
// Purely combinational, one half of the decoder
//////////////////////////////

`timescale 1ns/1ps

`include "pext_params.svh"

module pext_op_decoder import pext_pkg::*; (
  input  funct3_t funct3_i,
  input  funct7_t funct7_i,
  output op_hit_t table_hit_o
);

  pext_op_e table_op;

  always_comb begin
    table_op = PEXT_OP_NONE;
    case (funct3_i)
      `PEXT_F3_SIMD: begin
        case (funct7_i)
          // 16-bit add/sub
          7'b010_0000: table_op = PEXT_OP_ADD16;
          7'b000_1000: table_op = PEXT_OP_KADD16;
          7'b000_0000: table_op = PEXT_OP_RADD16;
          7'b001_1000: table_op = PEXT_OP_UKADD16;
          7'b001_0000: table_op = PEXT_OP_URADD16;
          7'b010_0001: table_op = PEXT_OP_SUB16;
          7'b000_1001: table_op = PEXT_OP_KSUB16;
          7'b000_0001: table_op = PEXT_OP_RSUB16;
          7'b001_1001: table_op = PEXT_OP_UKSUB16;
          7'b001_0001: table_op = PEXT_OP_URSUB16;
          // 8-bit add/sub
          7'b010_0100: table_op = PEXT_OP_ADD8;
          7'b000_1100: table_op = PEXT_OP_KADD8;
          7'b000_0100: table_op = PEXT_OP_RADD8;
          7'b001_1100: table_op = PEXT_OP_UKADD8;
          7'b001_0100: table_op = PEXT_OP_URADD8;
          7'b010_0101: table_op = PEXT_OP_SUB8;
          7'b000_1101: table_op = PEXT_OP_KSUB8;
          7'b000_0101: table_op = PEXT_OP_RSUB8;
          7'b001_1101: table_op = PEXT_OP_UKSUB8;
          7'b001_0101: table_op = PEXT_OP_URSUB8;
          // Compares
          7'b010_0110: table_op = PEXT_OP_CMPEQ16;
          7'b000_0110: table_op = PEXT_OP_SCMPLT16;
          7'b000_1110: table_op = PEXT_OP_SCMPLE16;
          7'b001_0110: table_op = PEXT_OP_UCMPLT16;
          7'b001_1110: table_op = PEXT_OP_UCMPLE16;
          7'b010_0111: table_op = PEXT_OP_CMPEQ8;
          7'b000_0111: table_op = PEXT_OP_SCMPLT8;
          7'b000_1111: table_op = PEXT_OP_SCMPLE8;
          7'b001_0111: table_op = PEXT_OP_UCMPLT8;
          7'b001_1111: table_op = PEXT_OP_UCMPLE8;
          // Min/max
          7'b100_0000: table_op = PEXT_OP_SMIN16;
          7'b100_0001: table_op = PEXT_OP_SMAX16;
          7'b100_1000: table_op = PEXT_OP_UMIN16;
          7'b100_1001: table_op = PEXT_OP_UMAX16;
          7'b100_0100: table_op = PEXT_OP_SMIN8;
          7'b100_0101: table_op = PEXT_OP_SMAX8;
          7'b100_1100: table_op = PEXT_OP_UMIN8;
          7'b100_1101: table_op = PEXT_OP_UMAX8;
          // Shifts, bit 4 of funct7 picks the immediate form
          7'b010_1000: table_op = PEXT_OP_SRA16;
          7'b011_1000: table_op = PEXT_OP_SRAI16;
          7'b010_1001: table_op = PEXT_OP_SRL16;
          7'b011_1001: table_op = PEXT_OP_SRLI16;
          7'b010_1010: table_op = PEXT_OP_SLL16;
          7'b011_1010: table_op = PEXT_OP_SLLI16;
          7'b010_1100: table_op = PEXT_OP_SRA8;
          7'b011_1100: table_op = PEXT_OP_SRAI8;
          7'b010_1101: table_op = PEXT_OP_SRL8;
          7'b011_1101: table_op = PEXT_OP_SRLI8;
          7'b010_1110: table_op = PEXT_OP_SLL8;
          7'b011_1110: table_op = PEXT_OP_SLLI8;
          // Unary funct7 codes fall through, the unary decoder owns them
          default:     table_op = PEXT_OP_NONE;
        endcase
      end

      `PEXT_F3_WORD: begin
        case (funct7_i)
          7'b000_0000: table_op = PEXT_OP_KADDW;
          7'b001_0000: table_op = PEXT_OP_RADDW;
          7'b000_1000: table_op = PEXT_OP_UKADDW;
          7'b001_1000: table_op = PEXT_OP_URADDW;
          7'b000_0001: table_op = PEXT_OP_KSUBW;
          7'b001_0001: table_op = PEXT_OP_RSUBW;
          7'b000_1001: table_op = PEXT_OP_UKSUBW;
          7'b001_1001: table_op = PEXT_OP_URSUBW;
          default:     table_op = PEXT_OP_NONE;
        endcase
      end

      default: table_op = PEXT_OP_NONE;
    endcase
  end

  // Every table entry is a real operator, so NONE means no match
  assign table_hit_o.hit = (table_op != PEXT_OP_NONE);
  assign table_hit_o.op  = table_op;

endmodule

/* logic/pext_params.svh */
//////////////////////////////
// Field positions and group codes for the packed-SIMD decoder
// Include wherever instruction fields are sliced or matched
//////////////////////////////

`ifndef PEXT_PARAMS_SVH
`define PEXT_PARAMS_SVH

// Instruction layout
`define PEXT_INSTR_W     32
`define PEXT_FUNCT3_LSB  12
`define PEXT_FUNCT3_W    3
`define PEXT_FUNCT7_LSB  25
`define PEXT_FUNCT7_W    7
`define PEXT_SUBF5_LSB   20
`define PEXT_SUBF5_W     5

// Operator code width, sized for NONE plus 66 kept operators
`define PEXT_OP_W        7

// funct3 groups
`define PEXT_F3_SIMD     3'b000
`define PEXT_F3_WORD     3'b001

// One-operand funct7 groups, selected further by subf5
`define PEXT_F7_UNARY1   7'b101_0110
`define PEXT_F7_UNARY2   7'b101_0111

`endif

/* logic/pext_pkg.sv */
//////////////////////////////
// Types shared by the packed-SIMD decoder blocks
// Modules import this package in their header
//////////////////////////////

`include "pext_params.svh"

package pext_pkg;

  typedef logic [`PEXT_INSTR_W-1:0]  instr_t;
  typedef logic [`PEXT_FUNCT3_W-1:0] funct3_t;
  typedef logic [`PEXT_FUNCT7_W-1:0] funct7_t;
  typedef logic [`PEXT_SUBF5_W-1:0]  subf5_t;

  // Operator codes, NONE is zero and the rest count up in this order
  typedef enum logic [`PEXT_OP_W-1:0] {
    PEXT_OP_NONE,
    // 16-bit add/sub, 1 to 10
    PEXT_OP_ADD16, PEXT_OP_KADD16, PEXT_OP_RADD16, PEXT_OP_UKADD16, PEXT_OP_URADD16,
    PEXT_OP_SUB16, PEXT_OP_KSUB16, PEXT_OP_RSUB16, PEXT_OP_UKSUB16, PEXT_OP_URSUB16,
    // 8-bit add/sub, 11 to 20
    PEXT_OP_ADD8,  PEXT_OP_KADD8,  PEXT_OP_RADD8,  PEXT_OP_UKADD8,  PEXT_OP_URADD8,
    PEXT_OP_SUB8,  PEXT_OP_KSUB8,  PEXT_OP_RSUB8,  PEXT_OP_UKSUB8,  PEXT_OP_URSUB8,
    // Compares, 21 to 30
    PEXT_OP_CMPEQ16, PEXT_OP_SCMPLT16, PEXT_OP_SCMPLE16, PEXT_OP_UCMPLT16, PEXT_OP_UCMPLE16,
    PEXT_OP_CMPEQ8,  PEXT_OP_SCMPLT8,  PEXT_OP_SCMPLE8,  PEXT_OP_UCMPLT8,  PEXT_OP_UCMPLE8,
    // Min/max, 31 to 38
    PEXT_OP_SMIN16, PEXT_OP_SMAX16, PEXT_OP_UMIN16, PEXT_OP_UMAX16,
    PEXT_OP_SMIN8,  PEXT_OP_SMAX8,  PEXT_OP_UMIN8,  PEXT_OP_UMAX8,
    // Shifts, 39 to 50
    PEXT_OP_SRA16, PEXT_OP_SRAI16, PEXT_OP_SRL16, PEXT_OP_SRLI16, PEXT_OP_SLL16, PEXT_OP_SLLI16,
    PEXT_OP_SRA8,  PEXT_OP_SRAI8,  PEXT_OP_SRL8,  PEXT_OP_SRLI8,  PEXT_OP_SLL8,  PEXT_OP_SLLI8,
    // 32-bit add/sub, 51 to 58
    PEXT_OP_KADDW, PEXT_OP_RADDW, PEXT_OP_UKADDW, PEXT_OP_URADDW,
    PEXT_OP_KSUBW, PEXT_OP_RSUBW, PEXT_OP_UKSUBW, PEXT_OP_URSUBW,
    // One-operand group, 59 to 66
    PEXT_OP_KABS8, PEXT_OP_KABS16, PEXT_OP_KABSW,
    PEXT_OP_CLRS8, PEXT_OP_CLRS16, PEXT_OP_CLRS32,
    PEXT_OP_CLZ8,  PEXT_OP_CLZ16
  } pext_op_e;

  // Result of one decoder part
  typedef struct packed {
    logic     hit;
    pext_op_e op;
  } op_hit_t;

  // Registered decode result
  typedef struct packed {
    pext_op_e op;
    logic     illegal;
    logic     imm_instr;
    subf5_t   imm;
    logic     width8;
    logic     width32;
    logic     signed_op;
  } pext_decode_t;

endpackage

/* logic/pext_unary_decoder.sv */
//////////////////////////////
// One-operand group decoder, keyed on the subf5 field
// Runs beside the two-operand table
//////////////////////////////

`timescale 1ns/1ps

`include "pext_params.svh"

module pext_unary_decoder import pext_pkg::*; (
  input  funct3_t funct3_i,
  input  funct7_t funct7_i,
  input  subf5_t  subf5_i,
  output op_hit_t unary_hit_o
);

  pext_op_e unary_op;
  logic     in_simd;

  assign in_simd = (funct3_i == `PEXT_F3_SIMD);

  always_comb begin
    unary_op = PEXT_OP_NONE;
    if (in_simd && funct7_i == `PEXT_F7_UNARY1) begin
      // Saturating absolute value
      case (subf5_i)
        5'b1_0000: unary_op = PEXT_OP_KABS8;
        5'b1_0001: unary_op = PEXT_OP_KABS16;
        5'b1_0100: unary_op = PEXT_OP_KABSW;
        default:   unary_op = PEXT_OP_NONE;
      endcase
    end else if (in_simd && funct7_i == `PEXT_F7_UNARY2) begin
      // Leading bit counts
      case (subf5_i)
        5'b0_0000: unary_op = PEXT_OP_CLRS8;
        5'b0_1000: unary_op = PEXT_OP_CLRS16;
        5'b1_1000: unary_op = PEXT_OP_CLRS32;
        5'b0_0001: unary_op = PEXT_OP_CLZ8;
        5'b0_1001: unary_op = PEXT_OP_CLZ16;
        default:   unary_op = PEXT_OP_NONE;
      endcase
    end
  end

  assign unary_hit_o.hit = (unary_op != PEXT_OP_NONE);
  assign unary_hit_o.op  = unary_op;

endmodule

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the output
verilator --binary --timing --assert -f build.f --top-module pext_decoder_tb -o pext_sim &&
  ./obj_dir/pext_sim | tee /dev/stderr | grep -q "Simulation PASSED" &&
  echo "run_sim: passed" || { echo "run_sim: failed"; exit 1; }

/* test/pext_decode_vectors.txt */
// Columns in hex: instr_illegal_op_imminstr_width8_width32_signed
// The all-F line marks the end of the vectors
40308177_0_01_0_0_0_1
30308177_0_04_0_0_0_0
08308177_0_0D_0_1_0_1
3A308177_0_13_0_1_0_0
0E308177_0_1B_0_1_0_1
82308177_0_20_0_0_0_1
70B08177_0_28_1_0_0_1
7C708177_0_32_1_1_0_0
73508177_0_2A_1_0_0_0
5A308177_0_2F_0_1_0_0
00309177_0_33_0_0_1_1
32309177_0_3A_0_0_1_0
AD108177_0_3C_0_0_0_1
AE008177_0_3E_0_1_0_1
AE908177_0_42_0_0_0_0
AF808177_0_40_0_0_1_1
4030B177_1_00_0_0_0_0
FE308177_1_00_0_0_0_0
AC008177_1_00_0_0_0_0
FFFFFFFF_F_FF_F_F_F_F

/* test/pext_decoder_properties.sv */
//////////////////////////////
// Concurrent checks on the merge stage, attached by bind
//////////////////////////////

`timescale 1ns/1ps

module pext_decoder_properties import pext_pkg::*; (
  input logic         clk_i,
  input logic         arst_n_i,
  input logic         instr_valid_i,
  input logic         decode_valid_o,
  input pext_decode_t decode_o
);

  // Valid is the strobe delayed by one cycle
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    instr_valid_i |=> decode_valid_o)
    else $error("valid missing one cycle after a strobe");

  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !instr_valid_i |=> !decode_valid_o)
    else $error("valid raised without a strobe");

  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    decode_o.illegal |-> decode_o.op == PEXT_OP_NONE)
    else $error("illegal result carries an operator");

  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !(decode_o.width8 && decode_o.width32))
    else $error("width8 and width32 both set");

  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    decode_o.imm_instr |-> !decode_o.illegal)
    else $error("immediate flag on an illegal result");

endmodule

bind pext_decode_merge pext_decoder_properties i_pext_decoder_properties (
  .clk_i          (clk_i),
  .arst_n_i       (arst_n_i),
  .instr_valid_i  (instr_valid_i),
  .decode_valid_o (decode_valid_o),
  .decode_o       (decode_o)
);

/* test/pext_decoder_tb.sv */
//////////////////////////////
// Testbench for the packed-SIMD decoder top
// Replays the vector file with random idle gaps and checks each result
//////////////////////////////

`timescale 1ns/1ps

module pext_decoder_tb import pext_pkg::*; ();

  localparam int          CLK_PERIOD = 8;
  localparam int          VEC_DEPTH  = 64;
  localparam logic [59:0] END_MARK   = {60{1'b1}};

  logic         clk;
  logic         arst_n;
  logic         instr_valid;
  instr_t       instr;
  logic         decode_valid;
  pext_decode_t decode;

  logic [59:0]  vec_mem [VEC_DEPTH];
  logic [59:0]  exp_vec;
  logic         pending;
  int           vec_count;
  int           err_count;
  int           seed;
  int           gap;

  pext_decoder_top i_pext_decoder_top (
    .clk_i          (clk),
    .arst_n_i       (arst_n),
    .instr_valid_i  (instr_valid),
    .instr_i        (instr),
    .decode_valid_o (decode_valid),
    .decode_o       (decode)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("Error at %0t ns: %s is %0h, expected %0h", $time, name, actual, expected);
      err_count++;
    end
  endtask

  // Result due now belongs to the strobe of the previous cycle
  task automatic check_output();
    check_value("decode_valid", 32'(decode_valid), 32'(pending));
    if (pending) begin
      check_value("illegal", 32'(decode.illegal), 32'(exp_vec[27:24]));
      check_value("op", 32'(decode.op), 32'(exp_vec[23:16]));
      check_value("imm_instr", 32'(decode.imm_instr), 32'(exp_vec[15:12]));
      check_value("imm", 32'(decode.imm), 32'(exp_vec[52:48]));
      check_value("width8", 32'(decode.width8), 32'(exp_vec[11:8]));
      check_value("width32", 32'(decode.width32), 32'(exp_vec[7:4]));
      check_value("signed_op", 32'(decode.signed_op), 32'(exp_vec[3:0]));
    end
  endtask

  task automatic drive_cycle(input logic valid, input logic [59:0] vec);
    @(negedge clk);
    check_output();
    instr_valid = valid;
    instr       = vec[59:28];
    pending     = valid;
    exp_vec     = vec;
  endtask

  initial begin
    clk         = 1'b0;
    arst_n      = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    pending     = 1'b0;
    exp_vec     = '0;
    err_count   = 0;
    vec_count   = 0;
    seed        = 32'h9e59;
    $readmemh("test/pext_decode_vectors.txt", vec_mem);
    while (vec_count < VEC_DEPTH && vec_mem[vec_count] !== END_MARK) begin
      vec_count++;
    end
    if (vec_count == 0) begin
      $display("No vectors were read from the vector file");
      err_count++;
    end
    // Output must stay cleared while reset is held
    for (int c = 0; c < 4; c++) begin
      @(negedge clk);
      // Register state is known once a rising edge has passed in reset
      if (c > 0) begin
        check_value("decode_valid in reset", 32'(decode_valid), 32'd0);
        check_value("decode in reset", 32'(decode), 32'd0);
      end
    end
    arst_n = 1'b1;
    for (int i = 0; i < vec_count; i++) begin
      gap = {$random(seed)} % 3;
      repeat (gap) begin
        drive_cycle(1'b0, '0);
      end
      drive_cycle(1'b1, vec_mem[i]);
    end
    // Drain the last result, then make sure no stray valid follows
    repeat (3) begin
      drive_cycle(1'b0, '0);
    end
    $display("Closing summary: %0d errors over %0d vectors", err_count, vec_count);
    if (err_count == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  //////////////////////////////
  // Watchdog
  //////////////////////////////
  initial begin
    int timeout_cycles;
    #1;
    timeout_cycles = vec_count * 4 + 50;
    #(timeout_cycles * CLK_PERIOD);
    $display("The simulation timed out after %0d cycles without finishing", timeout_cycles);
    $display("Simulation FAILED");
    $finish;
  end

endmodule
